//--- rtl/bench_pkg.sv
// shared widths, register map, engine state and command type for the memory benchmark
package bench_pkg;

   // apb bus
   localparam int APB_ADDR_W = 12;
   localparam int APB_DATA_W = 32;

   // benchmark field widths
   localparam int ADDR_W = 48;
   localparam int LEN_W  = 32;
   localparam int CYC_W  = 64;

   typedef logic [ADDR_W-1:0] addr_t;  // memory address and memory size
   typedef logic [LEN_W-1:0]  len_t;   // access count, chunk length, stride
   typedef logic [CYC_W-1:0]  cycles_t;

   // one benchmark run, base address sits in the low bits
   typedef struct packed {
      logic  is_write;
      len_t  stride;
      len_t  chunk_len;
      len_t  num_accesses;
      addr_t mem_size;
      addr_t base_addr;
   } bench_cmd_t;

   // host register offsets
   typedef enum logic [APB_ADDR_W-1:0] {
      REG_CTRL      = 12'h000,  // wo, bit0 queue run, bit1 is_write
      REG_BASE_LO   = 12'h004,
      REG_BASE_HI   = 12'h008,  // bits 47:32
      REG_SIZE_LO   = 12'h00C,
      REG_SIZE_HI   = 12'h010,  // bits 47:32
      REG_NUM_ACC   = 12'h014,
      REG_CHUNK     = 12'h018,
      REG_STRIDE    = 12'h01C,
      REG_STATUS    = 12'h020,  // ro, bit0 busy, bit1 fifo full
      REG_CYCLES_LO = 12'h024,  // ro
      REG_CYCLES_HI = 12'h028,  // ro
      REG_RUNS      = 12'h02C   // ro
   } reg_addr_e;

   typedef enum logic [0:0] {
      ENG_IDLE = 1'b0,
      ENG_RUN  = 1'b1
   } engine_state_e;

endpackage

//--- rtl/bench_cmd_if.sv
// valid/ready channel for one benchmark command, used between registers, FIFO and engine
`timescale 1ns/1ps

interface bench_cmd_if;
   import bench_pkg::*;

   logic       valid;  // sender holds until accepted
   logic       ready;
   bench_cmd_t cmd;

   modport sender (
      output valid,
      output cmd,
      input  ready
   );

   modport receiver (
      input  valid,
      input  cmd,
      output ready
   );

endinterface

//--- rtl/bench_apb_regs.sv
// APB register block: stages run parameters, queues commands and reports run results
`timescale 1ns/1ps

module bench_apb_regs (
   input  logic                            user_clk,
   input  logic                            user_aresetn,
   input  logic                            psel,
   input  logic                            penable,
   input  logic                            pwrite,
   input  logic [bench_pkg::APB_ADDR_W-1:0] paddr,
   input  logic [bench_pkg::APB_DATA_W-1:0] pwdata,
   output logic [bench_pkg::APB_DATA_W-1:0] prdata,
   output logic                            pready,
   output logic                            pslverr,
   bench_cmd_if.sender                     cmd_out,
   input  logic                            engine_busy,
   input  logic                            run_done,
   input  bench_pkg::cycles_t              run_cycles
);
   import bench_pkg::*;

   reg_addr_e reg_sel;
   logic      access;
   logic      dec_err;
   logic      wr_ok;
   logic      ctrl_start;
   logic      fifo_full;

   // staged run parameters
   addr_t base_q;
   addr_t size_q;
   len_t  num_acc_q;
   len_t  chunk_q;
   len_t  stride_q;

   // results
   cycles_t                 cycles_q;
   logic [APB_DATA_W-1:0]   runs_q;

   assign access     = psel & penable;  // access phase
   assign reg_sel    = reg_addr_e'(paddr);
   assign fifo_full  = ~cmd_out.ready;  // fifo drops ready only when full
   assign pready     = 1'b1;
   assign pslverr    = access & dec_err;
   assign wr_ok      = access & pwrite & ~dec_err;
   assign ctrl_start = wr_ok & (reg_sel == REG_CTRL) & pwdata[0];

   // read mux and error decode
   always_comb begin
      prdata  = '0;
      dec_err = 1'b0;
      case (reg_sel)
         REG_CTRL:      dec_err = ~pwrite | (pwdata[0] & fifo_full);
         REG_BASE_LO:   prdata = base_q[31:0];
         REG_BASE_HI:   prdata = APB_DATA_W'(base_q[ADDR_W-1:32]);
         REG_SIZE_LO:   prdata = size_q[31:0];
         REG_SIZE_HI:   prdata = APB_DATA_W'(size_q[ADDR_W-1:32]);
         REG_NUM_ACC:   prdata = num_acc_q;
         REG_CHUNK:     prdata = chunk_q;
         REG_STRIDE:    prdata = stride_q;
         REG_STATUS: begin
            prdata  = APB_DATA_W'({fifo_full, engine_busy});
            dec_err = pwrite;  // read only
         end
         REG_CYCLES_LO: begin
            prdata  = cycles_q[31:0];
            dec_err = pwrite;
         end
         REG_CYCLES_HI: begin
            prdata  = cycles_q[CYC_W-1:32];
            dec_err = pwrite;
         end
         REG_RUNS: begin
            prdata  = runs_q;
            dec_err = pwrite;
         end
         default:       dec_err = 1'b1;  // unmapped offset
      endcase
   end

   always_ff @(posedge user_clk) begin
      if (!user_aresetn) begin
         base_q        <= '0;
         size_q        <= '0;
         num_acc_q     <= '0;
         chunk_q       <= '0;
         stride_q      <= '0;
         cycles_q      <= '0;
         runs_q        <= '0;
         cmd_out.valid <= 1'b0;
      end else begin
         if (ctrl_start) begin
            cmd_out.valid <= 1'b1;
         end else if (cmd_out.valid && cmd_out.ready) begin
            cmd_out.valid <= 1'b0;  // taken by fifo
         end

         if (wr_ok) begin
            case (reg_sel)
               REG_BASE_LO: base_q[31:0]        <= pwdata;
               REG_BASE_HI: base_q[ADDR_W-1:32] <= pwdata[ADDR_W-33:0];
               REG_SIZE_LO: size_q[31:0]        <= pwdata;
               REG_SIZE_HI: size_q[ADDR_W-1:32] <= pwdata[ADDR_W-33:0];
               REG_NUM_ACC: num_acc_q           <= pwdata;
               REG_CHUNK:   chunk_q             <= pwdata;
               REG_STRIDE:  stride_q            <= pwdata;
               default:     ;
            endcase
         end

         if (run_done) begin
            cycles_q <= run_cycles;
            runs_q   <= runs_q + 1'b1;
         end
      end
   end

   // command snapshot, held while valid waits for the fifo
   always_ff @(posedge user_clk) begin
      if (ctrl_start) begin
         cmd_out.cmd <= '{
            is_write:     pwdata[1],
            stride:       stride_q,
            chunk_len:    chunk_q,
            num_accesses: num_acc_q,
            mem_size:     size_q,
            base_addr:    base_q
         };
      end
   end

endmodule

//--- rtl/bench_cmd_fifo.sv
// circular command queue between the register block and the access engine
`timescale 1ns/1ps

module bench_cmd_fifo #(
   parameter int FIFO_DEPTH = 4  // power of two, at least 2
) (
   input  logic          user_clk,
   input  logic          user_aresetn,
   bench_cmd_if.receiver cmd_in,
   bench_cmd_if.sender   cmd_out
);
   import bench_pkg::*;

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   bench_cmd_t       mem_q [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [PTR_W:0]   count_q;
   logic             push;
   logic             pop;

   assign cmd_in.ready  = (count_q != (PTR_W+1)'(FIFO_DEPTH));  // low when full
   assign cmd_out.valid = (count_q != '0);
   assign cmd_out.cmd   = mem_q[rd_ptr_q];

   assign push = cmd_in.valid & cmd_in.ready;
   assign pop  = cmd_out.valid & cmd_out.ready;

   always_ff @(posedge user_clk) begin
      if (!user_aresetn) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at depth
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: ;  // both or neither
         endcase
      end
   end

   // storage
   always_ff @(posedge user_clk) begin
      if (push) begin
         mem_q[wr_ptr_q] <= cmd_in.cmd;
      end
   end

endmodule

//--- rtl/mem_access_engine.sv
// access engine: issues one memory command per access of a run and times the run
`timescale 1ns/1ps

module mem_access_engine (
   input  logic             user_clk,
   input  logic             user_aresetn,
   bench_cmd_if.receiver    cmd_in,
   output logic             mem_cmd_valid,
   input  logic             mem_cmd_ready,
   output bench_pkg::addr_t mem_cmd_addr,
   output bench_pkg::len_t  mem_cmd_len,
   output logic             mem_cmd_write,
   output logic             busy,
   output logic             run_done,
   output bench_pkg::cycles_t run_cycles
);
   import bench_pkg::*;

   engine_state_e state_q;

   // latched run parameters
   addr_t base_q;
   addr_t size_q;
   len_t  chunk_q;
   len_t  stride_q;
   logic  write_q;

   addr_t   offset_q;
   len_t    remain_q;
   cycles_t cycles_q;
   logic    done_q;

   logic          accept;
   logic          mem_hs;
   logic [ADDR_W:0] step_sum;
   addr_t         offset_next;

   assign cmd_in.ready  = (state_q == ENG_IDLE);
   assign accept        = cmd_in.valid & cmd_in.ready;
   assign mem_cmd_valid = (state_q == ENG_RUN);
   assign mem_hs        = mem_cmd_valid & mem_cmd_ready;
   assign busy          = (state_q == ENG_RUN);

   assign mem_cmd_addr  = base_q + offset_q;
   assign mem_cmd_len   = chunk_q;
   assign mem_cmd_write = write_q;
   assign run_done      = done_q;
   assign run_cycles    = cycles_q;  // final count while run_done is high

   // next offset, one wrap back into the memory window
   always_comb begin
      step_sum = {1'b0, offset_q} + (ADDR_W+1)'(stride_q);
      if (step_sum >= {1'b0, size_q}) begin
         offset_next = addr_t'(step_sum - {1'b0, size_q});
      end else begin
         offset_next = step_sum[ADDR_W-1:0];
      end
   end

   always_ff @(posedge user_clk) begin
      if (!user_aresetn) begin
         state_q  <= ENG_IDLE;
         offset_q <= '0;
         remain_q <= '0;
         cycles_q <= '0;
         done_q   <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state_q)
            ENG_IDLE: begin
               if (accept) begin
                  offset_q <= '0;
                  remain_q <= cmd_in.cmd.num_accesses;
                  cycles_q <= '0;
                  if (cmd_in.cmd.num_accesses == '0) begin
                     done_q <= 1'b1;  // empty run
                  end else begin
                     state_q <= ENG_RUN;
                  end
               end
            end
            ENG_RUN: begin
               cycles_q <= cycles_q + 1'b1;  // every cycle valid is up
               if (mem_hs) begin
                  remain_q <= remain_q - 1'b1;
                  offset_q <= offset_next;
                  if (remain_q == len_t'(1)) begin
                     state_q <= ENG_IDLE;
                     done_q  <= 1'b1;
                  end
               end
            end
            default: state_q <= ENG_IDLE;
         endcase
      end
   end

   // run parameters, taken on accept
   always_ff @(posedge user_clk) begin
      if (accept) begin
         base_q   <= cmd_in.cmd.base_addr;
         size_q   <= cmd_in.cmd.mem_size;
         chunk_q  <= cmd_in.cmd.chunk_len;
         stride_q <= cmd_in.cmd.stride;
         write_q  <= cmd_in.cmd.is_write;
      end
   end

endmodule

//--- rtl/mem_bench_top.sv
// top level of the memory benchmark: APB registers, command FIFO and access engine
`timescale 1ns/1ps

module mem_bench_top #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                            user_clk,
   input  logic                            user_aresetn,
   // apb slave
   input  logic                            psel,
   input  logic                            penable,
   input  logic                            pwrite,
   input  logic [bench_pkg::APB_ADDR_W-1:0] paddr,
   input  logic [bench_pkg::APB_DATA_W-1:0] pwdata,
   output logic [bench_pkg::APB_DATA_W-1:0] prdata,
   output logic                            pready,
   output logic                            pslverr,
   // memory command port
   output logic                            mem_cmd_valid,
   input  logic                            mem_cmd_ready,
   output bench_pkg::addr_t                mem_cmd_addr,
   output bench_pkg::len_t                 mem_cmd_len,
   output logic                            mem_cmd_write
);
   import bench_pkg::*;

   logic    engine_busy;
   logic    run_done;
   cycles_t run_cycles;

   bench_cmd_if regs_to_fifo ();
   bench_cmd_if fifo_to_eng ();

   bench_apb_regs regs_i (
      .user_clk     (user_clk),
      .user_aresetn (user_aresetn),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .cmd_out      (regs_to_fifo.sender),
      .engine_busy  (engine_busy),
      .run_done     (run_done),
      .run_cycles   (run_cycles)
   );

   bench_cmd_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) fifo_i (
      .user_clk     (user_clk),
      .user_aresetn (user_aresetn),
      .cmd_in       (regs_to_fifo.receiver),
      .cmd_out      (fifo_to_eng.sender)
   );

   mem_access_engine engine_i (
      .user_clk      (user_clk),
      .user_aresetn  (user_aresetn),
      .cmd_in        (fifo_to_eng.receiver),
      .mem_cmd_valid (mem_cmd_valid),
      .mem_cmd_ready (mem_cmd_ready),
      .mem_cmd_addr  (mem_cmd_addr),
      .mem_cmd_len   (mem_cmd_len),
      .mem_cmd_write (mem_cmd_write),
      .busy          (engine_busy),
      .run_done      (run_done),
      .run_cycles    (run_cycles)
   );

endmodule

//--- verif/tb_mem_bench_util.svh
// LFSR, APB access and typed compare helpers, included inside the memory benchmark testbench

int          errors = 0;
logic [15:0] lfsr_state = 16'd29784;  // seed

// galois lfsr stepped once per bit taken
function automatic logic rand_bit();
   logic out;
   out = lfsr_state[0];
   lfsr_state = {1'b0, lfsr_state[15:1]} ^ (out ? 16'hB400 : 16'h0000);
   return out;
endfunction

function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] v;
   v = '0;
   for (int i = 0; i < n; i++) begin
      v = {v[30:0], rand_bit()};
   end
   return v;
endfunction

function automatic addr_t rand_addr(input int hi_bits);
   logic [31:0] hi;
   logic [31:0] lo;
   hi = rand_bits(hi_bits);
   lo = rand_bits(32);
   return addr_t'({hi, lo});
endfunction

// response sampled in the access phase before the completing edge
task automatic apb_transfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                            input logic [APB_DATA_W-1:0] wdata,
                            output logic [APB_DATA_W-1:0] rdata, output logic err);
   @(negedge user_clk);
   psel   = 1'b1;
   pwrite = wr;
   paddr  = addr;
   pwdata = wdata;
   @(negedge user_clk);
   penable = 1'b1;
   #(CLK_PERIOD / 4);
   rdata = prdata;
   err   = pslverr;
   check_flag("pready", pready, 1'b1);  // no wait states
   @(negedge user_clk);
   psel    = 1'b0;
   penable = 1'b0;
   pwrite  = 1'b0;
endtask

task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
   $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
   errors++;
endtask

task automatic check_addr(input string name, input addr_t got, input addr_t exp);
   if (got !== exp) mismatch(name, 64'(got), 64'(exp));
endtask

task automatic check_len(input string name, input len_t got, input len_t exp);
   if (got !== exp) mismatch(name, 64'(got), 64'(exp));
endtask

task automatic check_cycles(input string name, input cycles_t got, input cycles_t exp);
   if (got !== exp) mismatch(name, got, exp);
endtask

task automatic check_data(input string name, input logic [APB_DATA_W-1:0] got,
                          input logic [APB_DATA_W-1:0] exp);
   if (got !== exp) mismatch(name, 64'(got), 64'(exp));
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
   if (got !== exp) mismatch(name, 64'(got), 64'(exp));
endtask

task automatic write_reg(input logic [APB_ADDR_W-1:0] addr, input logic [APB_DATA_W-1:0] data);
   logic [APB_DATA_W-1:0] rdata_ignored;
   logic                  err;
   apb_transfer(1'b1, addr, data, rdata_ignored, err);
   check_flag("pslverr", err, 1'b0);
endtask

task automatic read_reg(input logic [APB_ADDR_W-1:0] addr, output logic [APB_DATA_W-1:0] data);
   logic err;
   apb_transfer(1'b0, addr, '0, data, err);
   check_flag("pslverr", err, 1'b0);
endtask

//--- verif/tb_mem_bench.sv
// directed APB and memory command testbench for the memory benchmark top level
`timescale 1ns/1ps

module tb_mem_bench;
   import bench_pkg::*;

   localparam int FIFO_DEPTH  = 4;
   localparam int CLK_PERIOD  = 100;
   localparam int RUN_TIMEOUT = 400;  // cycles allowed per run
   localparam int POLL_LIMIT  = 40;

   logic                  user_clk = 1'b0;
   logic                  user_aresetn;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [APB_ADDR_W-1:0] paddr;
   logic [APB_DATA_W-1:0] pwdata;
   logic [APB_DATA_W-1:0] prdata;
   logic                  pready;
   logic                  pslverr;
   logic                  mem_cmd_valid;
   logic                  mem_cmd_ready;
   addr_t                 mem_cmd_addr;
   len_t                  mem_cmd_len;
   logic                  mem_cmd_write;
   int                    tests_passed = 0;
   int                    tests_failed = 0;

   `include "tb_mem_bench_util.svh"

   mem_bench_top #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) dut_i (
      .user_clk      (user_clk),
      .user_aresetn  (user_aresetn),
      .psel          (psel),
      .penable       (penable),
      .pwrite        (pwrite),
      .paddr         (paddr),
      .pwdata        (pwdata),
      .prdata        (prdata),
      .pready        (pready),
      .pslverr       (pslverr),
      .mem_cmd_valid (mem_cmd_valid),
      .mem_cmd_ready (mem_cmd_ready),
      .mem_cmd_addr  (mem_cmd_addr),
      .mem_cmd_len   (mem_cmd_len),
      .mem_cmd_write (mem_cmd_write)
   );

   always #(CLK_PERIOD / 2) user_clk = ~user_clk;

   // reference wrap rule with one subtraction once the sum reaches the size
   function automatic addr_t ref_next_offset(input addr_t offset, input len_t stride,
                                             input addr_t size);
      logic [63:0] sum;
      sum = 64'(offset) + 64'(stride);
      if (sum >= 64'(size)) sum = sum - 64'(size);
      return addr_t'(sum);
   endfunction

   task automatic summarize_test(input string name, input int errs_at_start);
      if (errors == errs_at_start) begin
         tests_passed++;
         $display("test %s passed", name);
      end else begin
         tests_failed++;
         $display("test %s failed with %0d errors", name, errors - errs_at_start);
      end
   endtask

   task automatic program_run(input addr_t base, input addr_t size, input len_t num,
                              input len_t chunk, input len_t stride);
      write_reg(REG_BASE_LO, base[31:0]);
      write_reg(REG_BASE_HI, 32'(base[47:32]));
      write_reg(REG_SIZE_LO, size[31:0]);
      write_reg(REG_SIZE_HI, 32'(size[47:32]));
      write_reg(REG_NUM_ACC, num);
      write_reg(REG_CHUNK, chunk);
      write_reg(REG_STRIDE, stride);
   endtask

   task automatic read_cycles(output cycles_t cyc);
      logic [APB_DATA_W-1:0] lo;
      logic [APB_DATA_W-1:0] hi;
      read_reg(REG_CYCLES_LO, lo);
      read_reg(REG_CYCLES_HI, hi);
      cyc = {hi, lo};
   endtask

   task automatic wait_runs(input logic [APB_DATA_W-1:0] target);
      logic [APB_DATA_W-1:0] runs;
      int                    polls;
      polls = 0;
      read_reg(REG_RUNS, runs);
      while (runs < target && polls < POLL_LIMIT) begin
         read_reg(REG_RUNS, runs);
         polls++;
      end
      if (runs < target) begin
         $display("timed out waiting for REG_RUNS to reach %0d", target);
         errors++;
      end else begin
         check_data("REG_RUNS", runs, target);
      end
   endtask

   // memory command port must stay quiet for the given number of cycles
   task automatic expect_no_commands(input int cycles);
      logic valid_seen;
      valid_seen = 1'b0;
      for (int i = 0; i < cycles; i++) begin
         @(negedge user_clk);
         valid_seen = valid_seen | mem_cmd_valid;
      end
      check_flag("mem_cmd_valid", valid_seen, 1'b0);
   endtask

   // takes the memory commands of one run with ready decided on each falling edge
   task automatic collect_run(input addr_t base, input addr_t size, input len_t stride,
                              input len_t chunk, input logic wr, input int num,
                              input bit stall_rand, output int stalls);
      addr_t offset;
      int    seen;
      int    waited;
      logic  rdy;
      offset = '0;
      seen   = 0;
      waited = 0;
      stalls = 0;
      while (seen < num && waited < RUN_TIMEOUT) begin
         @(negedge user_clk);
         waited++;
         rdy = stall_rand ? rand_bit() : 1'b1;
         mem_cmd_ready = rdy;
         if (mem_cmd_valid && rdy) begin
            check_addr("mem_cmd_addr", mem_cmd_addr, base + offset);
            check_len("mem_cmd_len", mem_cmd_len, chunk);
            check_flag("mem_cmd_write", mem_cmd_write, wr);
            offset = ref_next_offset(offset, stride, size);
            seen++;
         end else if (mem_cmd_valid) begin
            stalls++;  // valid held and counted by the engine
         end
      end
      if (seen < num) begin
         $display("run timed out after %0d of %0d memory commands", seen, num);
         errors++;
      end
   endtask

   task automatic do_run(input addr_t base, input addr_t size, input len_t num, input len_t chunk,
                         input len_t stride, input logic wr, input bit stall_rand);
      logic [APB_DATA_W-1:0] runs0;
      cycles_t               cyc;
      int                    stalls;
      read_reg(REG_RUNS, runs0);
      program_run(base, size, num, chunk, stride);
      write_reg(REG_CTRL, {30'd0, wr, 1'b1});
      collect_run(base, size, stride, chunk, wr, num, stall_rand, stalls);
      wait_runs(runs0 + 1);
      read_cycles(cyc);
      check_cycles("REG_CYCLES", cyc, cycles_t'(num) + cycles_t'(stalls));
   endtask

   task automatic register_readback();
      reg_addr_e             regs [7];
      logic [APB_DATA_W-1:0] masks [7];
      logic [APB_DATA_W-1:0] v;
      logic [APB_DATA_W-1:0] r;
      int                    e0;
      e0 = errors;
      regs  = '{REG_BASE_LO, REG_BASE_HI, REG_SIZE_LO, REG_SIZE_HI,
                REG_NUM_ACC, REG_CHUNK, REG_STRIDE};
      masks = '{32'hFFFF_FFFF, 32'h0000_FFFF, 32'hFFFF_FFFF, 32'h0000_FFFF,  // hi words 16 bits
                32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF};
      read_reg(REG_STATUS, r);
      check_data("REG_STATUS", r, '0);
      read_reg(REG_CYCLES_LO, r);
      check_data("REG_CYCLES_LO", r, '0);
      read_reg(REG_CYCLES_HI, r);
      check_data("REG_CYCLES_HI", r, '0);
      read_reg(REG_RUNS, r);
      check_data("REG_RUNS", r, '0);
      for (int i = 0; i < 7; i++) begin
         v = rand_bits(32);
         write_reg(regs[i], v);
         read_reg(regs[i], r);
         check_data(regs[i].name(), r, v & masks[i]);
      end
      summarize_test("register readback", e0);
   endtask

   task automatic read_runs_no_stall();
      addr_t size;
      int    e0;
      e0 = errors;
      for (int i = 0; i < 8; i++) begin
         size = addr_t'(rand_bits(20)) | 48'h1000;  // always above the 12 bit stride
         do_run(rand_addr(16), size, 4 + rand_bits(3), rand_bits(16), rand_bits(12),
                1'b0, 1'b0);
      end
      summarize_test("read runs", e0);
   endtask

   task automatic write_runs_wrapped();
      addr_t size;
      len_t  stride;
      int    e0;
      e0 = errors;
      for (int i = 0; i < 2; i++) begin
         size   = 48'h3000 + addr_t'(rand_bits(10));
         stride = len_t'(size / 3) + 1 + rand_bits(8);  // over a third so it wraps often
         do_run(rand_addr(16), size, 12, rand_bits(16), stride, 1'b1, 1'b1);
      end
      summarize_test("wrapped write runs", e0);
   endtask

   task automatic queue_overflow();
      addr_t                 bases [$];
      logic [APB_DATA_W-1:0] runs0;
      logic [APB_DATA_W-1:0] status;
      logic [APB_DATA_W-1:0] rdata;
      logic                  err;
      int                    stalls;
      int                    e0;
      e0 = errors;
      @(negedge user_clk);
      mem_cmd_ready = 1'b0;
      read_reg(REG_RUNS, runs0);
      program_run(48'h0, 48'h1000, 2, 32'h20, 32'h100);
      // one run parks in the engine while the rest fill the FIFO
      for (int i = 0; i <= FIFO_DEPTH; i++) begin
         bases.push_back(rand_addr(16));
         write_reg(REG_BASE_LO, bases[i][31:0]);
         write_reg(REG_BASE_HI, 32'(bases[i][47:32]));
         write_reg(REG_CTRL, 32'h1);
      end
      read_reg(REG_STATUS, status);
      check_data("REG_STATUS", status, 32'h3);  // busy and full
      apb_transfer(1'b1, REG_CTRL, 32'h1, rdata, err);
      check_flag("pslverr", err, 1'b1);
      foreach (bases[i]) begin
         collect_run(bases[i], 48'h1000, 32'h100, 32'h20, 1'b0, 2, 1'b0, stalls);
      end
      expect_no_commands(8);  // rejected run never starts
      wait_runs(runs0 + FIFO_DEPTH + 1);
      read_reg(REG_STATUS, status);
      check_data("REG_STATUS", status, 32'h0);
      summarize_test("queue overflow", e0);
   endtask

   task automatic bus_errors_and_empty_run();
      logic [APB_DATA_W-1:0] runs0;
      logic [APB_DATA_W-1:0] rdata;
      logic                  err;
      cycles_t               cyc;
      int                    e0;
      e0 = errors;
      apb_transfer(1'b0, 12'h030, '0, rdata, err);
      check_flag("pslverr", err, 1'b1);
      apb_transfer(1'b1, REG_RUNS, 32'h5, rdata, err);
      check_flag("pslverr", err, 1'b1);
      read_reg(REG_RUNS, runs0);
      program_run(rand_addr(16), 48'h1000, 0, 32'h20, 32'h100);
      write_reg(REG_CTRL, 32'h1);
      expect_no_commands(8);  // covers accept and done
      wait_runs(runs0 + 1);
      read_cycles(cyc);
      check_cycles("REG_CYCLES", cyc, '0);
      summarize_test("bus errors and empty run", e0);
   endtask

   initial begin
      user_aresetn  = 1'b0;
      psel          = 1'b0;
      penable       = 1'b0;
      pwrite        = 1'b0;
      paddr         = '0;
      pwdata        = '0;
      mem_cmd_ready = 1'b0;
      repeat (10) @(negedge user_clk);
      user_aresetn = 1'b1;
      register_readback();
      read_runs_no_stall();
      write_runs_wrapped();
      queue_overflow();
      bus_errors_and_empty_run();
      $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

//--- src.f
+incdir+verif
rtl/bench_pkg.sv
rtl/bench_cmd_if.sv
rtl/bench_apb_regs.sv
rtl/bench_cmd_fifo.sv
rtl/mem_access_engine.sv
rtl/mem_bench_top.sv
verif/tb_mem_bench.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= tb_mem_bench
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
